/* merge_pkg.sv */
package merge_pkg;

   localparam int data_w  = 32;
   localparam int lanes   = 32;
   localparam int delay_w = 7;
   localparam int lane_w  = 5;
   localparam int addr_w  = 12;
   localparam int level_w = 6;   // Holds 0 to lanes inclusive

   typedef logic [data_w-1:0]  data_t;
   typedef logic [delay_w-1:0] delay_t;
   typedef logic [lane_w-1:0]  lane_t;
   typedef logic [addr_w-1:0]  addr_t;
   typedef logic [level_w-1:0] level_t;

   localparam addr_t reg_ctrl   = 12'h000;
   localparam addr_t reg_delay  = 12'h004;
   localparam addr_t reg_result = 12'h008;
   localparam addr_t reg_level  = 12'h00C;
   localparam addr_t bank_base  = 12'h100;

   // Address bits that select a lane inside the bank window
   localparam addr_t bank_mask  = addr_t'((lanes - 1) * 4);

   typedef enum logic [1:0] {
      s_idle,
      s_load,
      s_run
   } seq_state_t;

endpackage

/* merge_apb_regs.sv */
module merge_apb_regs (
   input  logic               clk,
   input  logic               rst,
   input  merge_pkg::addr_t   paddr,
   input  logic               psel,
   input  logic               penable,
   input  logic               pwrite,
   input  merge_pkg::data_t   pwdata,
   output merge_pkg::data_t   prdata,
   output logic               pready,
   output logic               pslverr,
   input  logic               busy,
   input  logic               done,
   input  merge_pkg::data_t   head,
   input  merge_pkg::level_t  level,
   input  logic               empty,
   output logic               start_req,
   output logic               bank_we,
   output merge_pkg::lane_t   bank_idx,
   output merge_pkg::data_t   bank_wdata,
   output logic               pop,
   output merge_pkg::delay_t  delay_cfg
);
   import merge_pkg::*;

   logic access;
   logic hit_ctrl;
   logic hit_delay;
   logic hit_result;
   logic hit_level;
   logic hit_bank;
   logic err;

   assign access     = psel & penable;   // Every transfer ends in its access phase
   assign hit_ctrl   = (paddr == reg_ctrl);
   assign hit_delay  = (paddr == reg_delay);
   assign hit_result = (paddr == reg_result);
   assign hit_level  = (paddr == reg_level);
   assign hit_bank   = ((paddr & ~bank_mask) == bank_base);

   always_comb begin
      err = 1'b0;
      if (!(hit_ctrl || hit_delay || hit_result || hit_level || hit_bank)) begin
         err = 1'b1;
      end else if (!pwrite) begin
         err = hit_bank || (hit_result && empty);   // Bank is write only
      end else begin
         err = (hit_bank || hit_delay) && busy;   // Configuration is frozen during a run
      end
   end

   assign pready  = 1'b1;
   assign pslverr = access & err;

   // A start while busy is dropped quietly
   assign start_req  = access & pwrite & hit_ctrl & pwdata[0] & ~busy;
   assign bank_we    = access & pwrite & hit_bank & ~err;
   assign bank_idx   = paddr[lane_w+1:2];
   assign bank_wdata = pwdata;
   assign pop        = access & ~pwrite & hit_result & ~err;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         delay_cfg <= '0;
      end else if (access && pwrite && hit_delay && !err) begin
         delay_cfg <= pwdata[delay_w-1:0];
      end
   end

   always_comb begin
      prdata = '0;
      if (hit_ctrl) begin
         prdata = {{(data_w - 2){1'b0}}, done, busy};
      end else if (hit_delay) begin
         prdata = data_t'(delay_cfg);
      end else if (hit_result) begin
         prdata = head;   // Word being popped in this access
      end else if (hit_level) begin
         prdata = data_t'(level);
      end
   end

endmodule

/* word_bank.sv */
module word_bank (
   input  logic                                       clk,
   input  logic                                       rst,
   input  logic                                       we,
   input  merge_pkg::lane_t                           idx,
   input  merge_pkg::data_t                           wdata,
   output merge_pkg::data_t [merge_pkg::lanes-1:0]    lane_words
);

   // Lanes are static while a run is active, the register block blocks writes then
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         lane_words <= '0;
      end else if (we) begin
         lane_words[idx] <= wdata;
      end
   end

endmodule

/* run_sequencer.sv */
module run_sequencer (
   input  logic clk,
   input  logic rst,
   input  logic start_req,
   input  logic word_last,
   output logic run,
   output logic running,
   output logic clear,
   output logic busy,
   output logic done
);
   import merge_pkg::*;

   seq_state_t state;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= s_idle;
         done  <= 1'b0;
      end else begin
         case (state)
            s_idle: begin
               if (start_req) begin
                  state <= s_load;
                  done  <= 1'b0;   // Cleared together with the rise of busy
               end
            end
            s_load: begin
               state <= s_run;
            end
            s_run: begin
               if (word_last) begin
                  state <= s_idle;
                  done  <= 1'b1;
               end
            end
            default: begin
               state <= s_idle;
            end
         endcase
      end
   end

   assign run     = (state == s_load);   // One cycle, loads the merge counters
   assign clear   = (state == s_load);
   assign running = (state == s_run);
   assign busy    = (state != s_idle);

endmodule

/* word_merge.sv */
module word_merge (
   input  logic                                       clk,
   input  logic                                       rst,
   input  logic                                       run,
   input  logic                                       running,
   input  merge_pkg::data_t [merge_pkg::lanes-1:0]    lane_words,
   input  merge_pkg::delay_t                          delay_cfg,
   output merge_pkg::data_t                           word,
   output logic                                       word_valid,
   output logic                                       word_last
);
   import merge_pkg::*;

   delay_t delay_cnt;
   lane_t  lane_cnt;
   logic   pending;   // Lanes remain to be sent in this run
   logic   emit;

   assign emit = running && pending && (delay_cnt == '0);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         delay_cnt  <= '0;
         lane_cnt   <= '0;
         pending    <= 1'b0;
         word_valid <= 1'b0;
         word_last  <= 1'b0;
      end else if (run) begin
         delay_cnt  <= delay_cfg;
         lane_cnt   <= '0;
         pending    <= 1'b1;
         word_valid <= 1'b0;
         word_last  <= 1'b0;
      end else begin
         word_valid <= emit;
         word_last  <= emit && (lane_cnt == lane_t'(lanes - 1));
         if (running && pending && delay_cnt != '0) begin
            delay_cnt <= delay_cnt - 1'b1;
         end
         if (emit) begin
            lane_cnt <= lane_cnt + 1'b1;
            if (lane_cnt == lane_t'(lanes - 1)) begin
               pending <= 1'b0;   // Stop after lane 31 even though running is still high
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (emit) begin
         word <= lane_words[lane_cnt];
      end
   end

endmodule

/* result_fifo.sv */
module result_fifo (
   input  logic              clk,
   input  logic              rst,
   input  logic              clear,
   input  logic              push,
   input  merge_pkg::data_t  din,
   input  logic              pop,
   output merge_pkg::data_t  head,
   output merge_pkg::level_t level,
   output logic              empty
);
   import merge_pkg::*;

   data_t mem [lanes];
   lane_t wr_ptr;
   lane_t rd_ptr;
   logic  do_push;
   logic  do_pop;

   assign empty   = (level == '0);
   assign do_push = push && (level != level_t'(lanes));   // One run fills it exactly
   assign do_pop  = pop && !empty;
   assign head    = mem[rd_ptr];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         level  <= '0;
      end else if (clear) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         level  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (do_push && !do_pop) begin
            level <= level + 1'b1;
         end else if (do_pop && !do_push) begin
            level <= level - 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (do_push && !clear) begin
         mem[wr_ptr] <= din;
      end
   end

endmodule

/* merge_top.sv */
module merge_top (
   input  logic             clk,
   input  logic             rst,
   input  merge_pkg::addr_t paddr,
   input  logic             psel,
   input  logic             penable,
   input  logic             pwrite,
   input  merge_pkg::data_t pwdata,
   output merge_pkg::data_t prdata,
   output logic             pready,
   output logic             pslverr
);
   import merge_pkg::*;

   logic              start_req;
   logic              bank_we;
   lane_t             bank_idx;
   data_t             bank_wdata;
   logic              pop;
   delay_t            delay_cfg;
   data_t [lanes-1:0] lane_words;
   logic              run;
   logic              running;
   logic              clear;
   logic              busy;
   logic              done;
   data_t             word;
   logic              word_valid;
   logic              word_last;
   data_t             head;
   level_t            level;
   logic              empty;

   merge_apb_regs regs0 (
      .clk        (clk),
      .rst        (rst),
      .paddr      (paddr),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .pwdata     (pwdata),
      .prdata     (prdata),
      .pready     (pready),
      .pslverr    (pslverr),
      .busy       (busy),
      .done       (done),
      .head       (head),
      .level      (level),
      .empty      (empty),
      .start_req  (start_req),
      .bank_we    (bank_we),
      .bank_idx   (bank_idx),
      .bank_wdata (bank_wdata),
      .pop        (pop),
      .delay_cfg  (delay_cfg)
   );

   word_bank bank0 (
      .clk        (clk),
      .rst        (rst),
      .we         (bank_we),
      .idx        (bank_idx),
      .wdata      (bank_wdata),
      .lane_words (lane_words)
   );

   run_sequencer seq0 (
      .clk       (clk),
      .rst       (rst),
      .start_req (start_req),
      .word_last (word_last),
      .run       (run),
      .running   (running),
      .clear     (clear),
      .busy      (busy),
      .done      (done)
   );

   word_merge merge0 (
      .clk        (clk),
      .rst        (rst),
      .run        (run),
      .running    (running),
      .lane_words (lane_words),
      .delay_cfg  (delay_cfg),
      .word       (word),
      .word_valid (word_valid),
      .word_last  (word_last)
   );

   result_fifo fifo0 (
      .clk   (clk),
      .rst   (rst),
      .clear (clear),
      .push  (word_valid),
      .din   (word),
      .pop   (pop),
      .head  (head),
      .level (level),
      .empty (empty)
   );

endmodule

/* tb_merge_assertions.sv */
module tb_merge_assertions (
   input logic clk,
   input logic rst,
   input logic pready,
   input logic run,
   input logic running,
   input logic word_valid,
   input logic busy,
   input logic done
);
   timeunit 1ns;
   timeprecision 1ps;

   pready_high: assert property (@(posedge clk) disable iff (rst) pready)
      else $error("pready went low");

   run_one_cycle: assert property (@(posedge clk) disable iff (rst) run |=> !run)
      else $error("run lasted more than one cycle");

   // Running falls one cycle after the last word is registered
   valid_in_run: assert property (@(posedge clk) disable iff (rst)
      word_valid |-> (running || $past(running)))
      else $error("word_valid outside a run");

   done_not_busy: assert property (@(posedge clk) disable iff (rst) !(done && busy))
      else $error("done and busy high together");

endmodule

bind merge_top tb_merge_assertions asrt0 (
   .clk        (clk),
   .rst        (rst),
   .pready     (pready),
   .run        (run),
   .running    (running),
   .word_valid (word_valid),
   .busy       (busy),
   .done       (done)
);

/* tb_merge.sv */
module tb_merge;
   timeunit 1ns;
   timeprecision 1ps;
   import merge_pkg::*;

   localparam int n_rows = 6;

   logic  clk;
   logic  rst;
   addr_t paddr;
   logic  psel;
   logic  penable;
   logic  pwrite;
   data_t pwdata;
   data_t prdata;
   logic  pready;
   logic  pslverr;
   int    cycle_cnt = 0;

   // Fill modes are 0 for the index pattern, 1 for random words, 2 for all ones
   int    row_delay [n_rows] = '{0, 1, 17, 127, 5, 40};
   int    row_fill  [n_rows] = '{0, 1, 2, 1, 0, 1};
   addr_t row_addr  [n_rows] = '{12'h004, 12'h104, 12'h000, 12'h200, 12'h140, 12'h17C};
   int    row_write [n_rows] = '{1, 1, 1, 0, 0, 1};
   int    row_err   [n_rows] = '{1, 1, 0, 1, 1, 1};
   int    row_keep  [n_rows] = '{0, 0, 0, 0, 1, 0};   // Leave words behind for the next run
   int    run_cycles [n_rows];

   merge_top dut0 (
      .clk     (clk),
      .rst     (rst),
      .paddr   (paddr),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

   task automatic stop_with_failure();
      $display("Simulation failed");
      $fatal(1, "Stopping at the first error");
   endtask

   task automatic check(string name, data_t actual, data_t expected);
      if (actual !== expected) begin
         $display("Fail %s: got 0x%08h, expected 0x%08h", name, actual, expected);
         stop_with_failure();
      end
   endtask

   task automatic apb_transfer(addr_t addr, logic write, data_t wdata,
                               output data_t rdata, output logic err);
      int waited;
      waited = 0;
      @(posedge clk);
      #1;
      paddr   = addr;
      pwrite  = write;
      pwdata  = wdata;
      psel    = 1'b1;
      penable = 1'b0;
      @(posedge clk);
      #1 penable = 1'b1;
      @(negedge clk);
      while (!pready) begin
         waited++;
         if (waited > 16) begin
            $display("Timeout: the APB transfer never completed");
            stop_with_failure();
         end
         @(negedge clk);
      end
      rdata = prdata;
      err   = pslverr;
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_write(addr_t addr, data_t wdata, output logic err);
      data_t unused_rd;
      apb_transfer(addr, 1'b1, wdata, unused_rd, err);
   endtask

   task automatic apb_read(addr_t addr, output data_t rdata, output logic err);
      apb_transfer(addr, 1'b0, '0, rdata, err);
   endtask

   task automatic wait_done(output int done_cycle);
      data_t rd;
      logic  err;
      int    polls;
      polls = 0;
      apb_read(reg_ctrl, rd, err);
      while (rd[1] !== 1'b1) begin
         polls++;
         if (polls > 200) begin
            $display("Timeout: the run never reported done");
            stop_with_failure();
         end
         apb_read(reg_ctrl, rd, err);
      end
      done_cycle = cycle_cnt;
   endtask

   task automatic run_row(int r);
      data_t exp_words [lanes];
      data_t value;
      data_t rd;
      logic  err;
      int    t_start;
      int    t_done;
      int    pops;
      for (int i = 0; i < lanes; i++) begin
         case (row_fill[r])
            0:       value = {8'hA5, 16'h0000, 8'(i)};
            1:       value = $urandom;
            default: value = 32'hFFFF_FFFF;
         endcase
         exp_words[i] = value;
         apb_write(bank_base + addr_t'(4 * i), value, err);
         check("pslverr", data_t'(err), 32'h0);
      end
      apb_write(reg_delay, data_t'(row_delay[r]), err);
      check("pslverr", data_t'(err), 32'h0);
      apb_write(reg_ctrl, 32'h1, err);
      t_start = cycle_cnt;
      check("pslverr", data_t'(err), 32'h0);
      apb_read(reg_ctrl, rd, err);
      check("ctrl", rd, 32'h1);   // Busy with done cleared by the new run
      if (row_write[r] != 0) begin
         apb_write(row_addr[r], 32'hDEAD_BEEF, err);
      end else begin
         apb_read(row_addr[r], rd, err);
      end
      check("probe pslverr", data_t'(err), data_t'(row_err[r]));
      wait_done(t_done);
      run_cycles[r] = t_done - t_start;
      check("run_long_enough", data_t'(run_cycles[r] >= row_delay[r] + 32), 32'h1);
      for (int p = 0; p < r; p++) begin
         if (row_delay[r] > row_delay[p]) begin
            check("run_not_shorter", data_t'(run_cycles[r] >= run_cycles[p]), 32'h1);
         end
      end
      apb_read(reg_delay, rd, err);
      check("delay", rd, data_t'(row_delay[r]));
      apb_read(reg_level, rd, err);
      check("level", rd, 32'd32);
      pops = (row_keep[r] != 0) ? 8 : lanes;
      for (int i = 0; i < pops; i++) begin
         apb_read(reg_result, rd, err);
         check("pslverr", data_t'(err), 32'h0);
         check($sformatf("result lane %0d", i), rd, exp_words[i]);
      end
      if (row_keep[r] == 0) begin
         apb_read(reg_level, rd, err);
         check("level", rd, 32'h0);
         apb_read(reg_result, rd, err);
         check("empty pop pslverr", data_t'(err), 32'h1);
      end
   endtask

   initial begin
      data_t rd;
      logic  err;
      rst     = 1'b1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      void'($urandom(32'hc164_3bf4));
      repeat (4) @(posedge clk);
      #1 rst = 1'b0;
      apb_read(reg_ctrl, rd, err);
      check("ctrl", rd, 32'h0);
      apb_read(reg_delay, rd, err);
      check("delay", rd, 32'h0);
      apb_read(reg_level, rd, err);
      check("level", rd, 32'h0);
      apb_read(reg_result, rd, err);
      check("empty pop pslverr", data_t'(err), 32'h1);
      for (int r = 0; r < n_rows; r++) begin
         run_row(r);
      end
      $display("Simulation passed");
      $finish;
   end

endmodule

/* verilog.f */
merge_pkg.sv
merge_apb_regs.sv
word_bank.sv
run_sequencer.sv
word_merge.sv
result_fifo.sv
merge_top.sv
tb_merge_assertions.sv
tb_merge.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it; the exit status is the result
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_merge \
   -f verilog.f --Mdir obj_dir -o tb_merge_sim
./obj_dir/tb_merge_sim
